//--- Makefile
# Verilator build for the expanded-slot subsystem testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_msx_extslot
FILELIST  = msx_extslot.f
BUILD_DIR = obj_dir
LOG       = sim.log

SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the simulator exit code
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- msx_extslot.f
verilog/msx_bus_pkg.sv
verilog/msx_cmd_fifo.sv
verilog/msx_bus_master.sv
verilog/ip_extslot.sv
verilog/sub_slot_ram.sv
verilog/msx_extslot_top.sv
verification/tb_msx_extslot.sv

//--- verification/tb_msx_extslot.sv
`timescale 1ns/10ps
`default_nettype none

module tb_msx_extslot import msx_bus_pkg::*; ();

	// Directed part needs a few hundred cycles, each random command at most
	// about 40 cycles with ready stalls, so 200 commands fit with a wide margin
	localparam int WATCHDOG_CYCLES = 20000;
	localparam int RANDOM_CMDS = 200;

	logic clk;
	logic n_reset;
	logic cmd_valid;
	logic cmd_ready;
	logic cmd_write;
	bus_addr_t cmd_address;
	bus_data_t cmd_wdata;
	logic rsp_valid;
	logic rsp_ready;
	bus_data_t rsp_rdata;

	// ----------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------
	slot_reg_t model_reg;
	bus_data_t model_mem [4][256];
	// RAM bytes with a known value, the DUT RAMs start undefined
	logic model_known [4][256];
	// Expected read data in command order
	bus_data_t exp_q [$];
	bus_data_t rsp_exp;

	string test_name;
	int tests_run;
	int tests_failed;
	int checks;
	int errors;
	int test_errors_start;
	logic toggle_en;
	integer seed;
	integer ready_seed;
	integer ready_bits;

	msx_extslot_top UUT (
		.clk(clk),
		.n_reset(n_reset),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_write(cmd_write),
		.cmd_address(cmd_address),
		.cmd_wdata(cmd_wdata),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp_rdata(rsp_rdata)
	);

	always #50 clk = ~clk;

	// Subslot named by the register field of the address's page
	function automatic subslot_t page_subslot(input bus_addr_t addr);
		return subslot_t'(model_reg >> (2 * addr[15:14]));
	endfunction

	function automatic bus_data_t expected_read(input bus_addr_t addr);
		if (addr == EXTSLOT_ADDR) begin
			return ~model_reg;
		end
		return model_mem[page_subslot(addr)][addr[7:0]];
	endfunction

	// ----------------------------------------------------------
	// Host side drivers
	// ----------------------------------------------------------
	// Called 1 ns after a rising edge, returns at the same point
	task automatic send_cmd(input logic is_write, input bus_addr_t addr, input bus_data_t data);
		subslot_t sub;
		sub = page_subslot(addr);
		if (is_write) begin
			if (addr == EXTSLOT_ADDR) begin
				model_reg = data;
			end else begin
				model_mem[sub][addr[7:0]] = data;
				model_known[sub][addr[7:0]] = 1'b1;
			end
		end else begin
			exp_q.push_back(expected_read(addr));
		end
		cmd_valid = 1'b1;
		cmd_write = is_write;
		cmd_address = addr;
		cmd_wdata = data;
		// Transfer on the edge after a negedge that sees cmd_ready
		@(negedge clk);
		while (cmd_ready !== 1'b1) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	// Responses are checked by the monitor, this only waits for the queue
	task automatic wait_responses();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		wait_responses();
		if (errors != test_errors_start) begin
			tests_failed++;
			$display("%s: failed with %0d errors", test_name, errors - test_errors_start);
		end else begin
			$display("%s: passed", test_name);
		end
	endtask

	// ----------------------------------------------------------
	// Response monitor
	// ----------------------------------------------------------
	// Sampled mid-cycle, a handshake seen here completes on the next edge
	always @(negedge clk) begin
		if (rsp_valid === 1'b1 && rsp_ready === 1'b1) begin
			checks++;
			if (exp_q.size() == 0) begin
				$display("%s: response arrived with no read outstanding", test_name);
				errors++;
			end else begin
				rsp_exp = exp_q.pop_front();
				if (rsp_rdata !== rsp_exp) begin
					$display("Error %s: expected %02h, actual %02h", test_name, rsp_exp,
						rsp_rdata);
					errors++;
				end
			end
		end
	end

	// Random rsp_ready during the traffic test
	always @(posedge clk) begin
		#1;
		if (toggle_en) begin
			ready_bits = $random(ready_seed);
			rsp_ready = (ready_bits[1:0] != 2'b00);
		end
	end

	// ----------------------------------------------------------
	// Tests
	// ----------------------------------------------------------
	task automatic test_reset_state();
		start_test("reset_state");
		@(negedge clk);
		checks += 2;
		if (cmd_ready !== 1'b1) begin
			$display("Error %s: cmd_ready expected 1, actual %b", test_name, cmd_ready);
			errors++;
		end
		if (rsp_valid !== 1'b0) begin
			$display("Error %s: rsp_valid expected 0, actual %b", test_name, rsp_valid);
			errors++;
		end
		@(posedge clk);
		#1;
		// Cleared register reads back as FF
		send_cmd(1'b0, EXTSLOT_ADDR, '0);
		end_test();
	endtask

	task automatic test_register_readback();
		start_test("register_readback");
		send_cmd(1'b1, EXTSLOT_ADDR, 8'hA5);
		send_cmd(1'b0, EXTSLOT_ADDR, '0);
		end_test();
	endtask

	task automatic test_subslot_routing();
		start_test("subslot_routing");
		// 00, 55, AA, FF put page 0 on subslots 0 to 3
		for (int i = 0; i < 4; i++) begin
			send_cmd(1'b1, EXTSLOT_ADDR, slot_reg_t'(8'h55 * i));
			send_cmd(1'b1, 16'h1234, bus_data_t'(8'hC0 + i));
			// Reselect every subslot written so far
			for (int j = 0; j <= i; j++) begin
				send_cmd(1'b1, EXTSLOT_ADDR, slot_reg_t'(j));
				send_cmd(1'b0, 16'h1234, '0);
			end
		end
		end_test();
	endtask

	task automatic test_page_mapping();
		start_test("page_mapping");
		// E4 maps page n to subslot n
		send_cmd(1'b1, EXTSLOT_ADDR, 8'hE4);
		for (int p = 0; p < 4; p++) begin
			send_cmd(1'b1, bus_addr_t'(p * 16'h4000 + 16'h0010), bus_data_t'(8'h61 + p));
		end
		for (int p = 0; p < 4; p++) begin
			send_cmd(1'b0, bus_addr_t'(p * 16'h4000 + 16'h0010), '0);
		end
		// 3F10 lands on the same RAM byte as 0010
		send_cmd(1'b1, 16'h3F10, 8'h7E);
		send_cmd(1'b0, 16'h0010, '0);
		send_cmd(1'b0, 16'h7F10, '0);
		send_cmd(1'b0, 16'h8010, '0);
		end_test();
	endtask

	task automatic test_backpressure();
		int n;
		start_test("backpressure");
		rsp_ready = 1'b0;
		// One read sits in the master, four fill the FIFO
		for (int k = 0; k < 5; k++) begin
			send_cmd(1'b0, (k == 4) ? EXTSLOT_ADDR : bus_addr_t'(k * 16'h4000 + 16'h0010),
				'0);
		end
		n = 0;
		while (cmd_ready !== 1'b0 && n < 20) begin
			@(negedge clk);
			n++;
		end
		checks++;
		if (cmd_ready !== 1'b0) begin
			$display("%s: cmd_ready did not fall while responses were held", test_name);
			errors++;
		end
		@(posedge clk);
		#1;
		// Sixth read stalls until the host takes responses again
		fork
			send_cmd(1'b0, 16'h3F10, '0);
			begin
				repeat (6) @(posedge clk);
				#1;
				rsp_ready = 1'b1;
			end
		join
		end_test();
	endtask

	task automatic test_random_traffic();
		integer r;
		integer d;
		bus_addr_t addr;
		logic is_write;
		start_test("random_traffic");
		toggle_en = 1'b1;
		for (int n = 0; n < RANDOM_CMDS; n++) begin
			r = $random(seed);
			d = $random(seed);
			if (r[2:0] == 3'd0) begin
				addr = EXTSLOT_ADDR;
				is_write = 1'b1;
			end else if (r[2:0] == 3'd1) begin
				addr = EXTSLOT_ADDR;
				is_write = 1'b0;
			end else begin
				// Any page, upper bits alias, 16 bytes per RAM
				addr = {r[31:30], r[21:16], 4'h0, r[11:8]};
				is_write = r[3];
				// A byte never written has no model value, so write it instead
				if (!is_write && !model_known[page_subslot(addr)][addr[7:0]]) begin
					is_write = 1'b1;
				end
			end
			send_cmd(is_write, addr, d[7:0]);
		end
		toggle_en = 1'b0;
		@(posedge clk);
		#1;
		rsp_ready = 1'b1;
		end_test();
	endtask

	// ----------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------
	initial begin
		clk = 1'b0;
		n_reset = 1'b0;
		cmd_valid = 1'b0;
		cmd_write = 1'b0;
		cmd_address = '0;
		cmd_wdata = '0;
		rsp_ready = 1'b1;
		toggle_en = 1'b0;
		seed = 32'h6826c3e8;
		ready_seed = 32'h6826c3e8;
		model_reg = '0;
		tests_run = 0;
		tests_failed = 0;
		checks = 0;
		errors = 0;
		for (int s = 0; s < 4; s++) begin
			for (int b = 0; b < 256; b++) begin
				model_mem[s][b] = '0;
				model_known[s][b] = 1'b0;
			end
		end
		repeat (4) @(posedge clk);
		#1;
		n_reset = 1'b1;
		test_reset_state();
		test_register_readback();
		test_subslot_routing();
		test_page_mapping();
		test_backpressure();
		test_random_traffic();
		$display("Tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
			checks, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/ip_extslot.sv
`timescale 1ns/10ps
`default_nettype none

module ip_extslot import msx_bus_pkg::*; (
	input wire logic clk,
	input wire logic n_reset,
	// MSX-50BUS
	input wire bus_addr_t bus_address,
	input wire bus_data_t bus_write_data,
	input wire logic bus_read,
	input wire logic bus_write,
	input wire logic bus_memory,
	output logic bus_read_ready,
	output bus_data_t bus_read_data,
	// Subslot selects
	output logic extslot_memory0,
	output logic extslot_memory1,
	output logic extslot_memory2,
	output logic extslot_memory3
);
	logic w_extslot_dec;
	logic w_slot_hit;
	subslot_t w_page_sel;
	slot_reg_t ff_extslot_reg;
	logic ff_read_ready;

	// ----------------------------------------------------------
	// Address decode
	// ----------------------------------------------------------
	assign w_extslot_dec = (bus_address == EXTSLOT_ADDR);

	// ----------------------------------------------------------
	// Slot register and its readback
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_extslot_reg <= '0;
			ff_read_ready <= 1'b0;
		end else begin
			if (bus_memory && w_extslot_dec && bus_write) begin
				ff_extslot_reg <= bus_write_data;
			end
			// Answer one cycle after the read strobe
			ff_read_ready <= bus_memory && w_extslot_dec && bus_read;
		end
	end

	// Register reads back inverted, zero when idle so it can be ORed
	assign bus_read_ready = ff_read_ready;
	assign bus_read_data = ff_read_ready ? ~ff_extslot_reg : '0;

	// ----------------------------------------------------------
	// Subslot select
	// ----------------------------------------------------------
	// Field of the register for the 16 KB page being addressed
	always_comb begin
		case (bus_address[15:14])
			2'd0: w_page_sel = ff_extslot_reg[1:0];
			2'd1: w_page_sel = ff_extslot_reg[3:2];
			2'd2: w_page_sel = ff_extslot_reg[5:4];
			default: w_page_sel = ff_extslot_reg[7:6];
		endcase
	end

	// The register address itself never reaches a subslot
	assign w_slot_hit = bus_memory && !w_extslot_dec;

	assign extslot_memory0 = w_slot_hit && (w_page_sel == 2'd0);
	assign extslot_memory1 = w_slot_hit && (w_page_sel == 2'd1);
	assign extslot_memory2 = w_slot_hit && (w_page_sel == 2'd2);
	assign extslot_memory3 = w_slot_hit && (w_page_sel == 2'd3);

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	// Register and subslots are mutually exclusive targets
	a_one_target: assert property (@(posedge clk) disable iff (!n_reset)
		$onehot0({extslot_memory3, extslot_memory2, extslot_memory1,
			extslot_memory0, bus_memory && w_extslot_dec}));

endmodule

`default_nettype wire

//--- verilog/msx_bus_master.sv
`timescale 1ns/10ps
`default_nettype none

module msx_bus_master import msx_bus_pkg::*; (
	input wire logic clk,
	input wire logic n_reset,
	// Command queue from the FIFO
	input wire logic q_valid,
	output logic q_ready,
	input wire logic q_write,
	input wire bus_addr_t q_address,
	input wire bus_data_t q_wdata,
	// MSX-50BUS master side
	output bus_addr_t bus_address,
	output bus_data_t bus_write_data,
	output logic bus_read,
	output logic bus_write,
	output logic bus_memory,
	input wire logic bus_read_ready,
	input wire bus_data_t bus_read_data,
	// Host response port
	output logic rsp_valid,
	input wire logic rsp_ready,
	output bus_data_t rsp_rdata
);
	master_state_t ff_state;

	// Latched command and captured read byte
	logic ff_write;
	bus_addr_t ff_address;
	bus_data_t ff_wdata;
	bus_data_t ff_rdata;

	// ----------------------------------------------------------
	// Outputs decoded from the state
	// ----------------------------------------------------------
	// Only pop while nothing is in flight
	assign q_ready = (ff_state == IDLE);

	// Strobe lasts exactly the STROBE cycle
	assign bus_memory = (ff_state == STROBE);
	assign bus_read = (ff_state == STROBE) && !ff_write;
	assign bus_write = (ff_state == STROBE) && ff_write;
	assign bus_address = ff_address;
	assign bus_write_data = ff_wdata;

	// Response held until the host takes it
	assign rsp_valid = (ff_state == RESPOND);
	assign rsp_rdata = ff_rdata;

	// ----------------------------------------------------------
	// FSM
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_state <= IDLE;
		end else begin
			case (ff_state)
				IDLE: begin
					if (q_valid) begin
						ff_state <= STROBE;
					end
				end
				STROBE: begin
					// Writes finish with the strobe
					ff_state <= ff_write ? IDLE : WAIT_DATA;
				end
				WAIT_DATA: begin
					if (bus_read_ready) begin
						ff_state <= RESPOND;
					end
				end
				RESPOND: begin
					if (rsp_ready) begin
						ff_state <= IDLE;
					end
				end
				default: ff_state <= IDLE;
			endcase
		end
	end

	// Command latch on pop, read byte capture on ready
	always_ff @(posedge clk) begin
		if (q_valid && q_ready) begin
			ff_write <= q_write;
			ff_address <= q_address;
			ff_wdata <= q_wdata;
		end
		if ((ff_state == WAIT_DATA) && bus_read_ready) begin
			ff_rdata <= bus_read_data;
		end
	end

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	// One-cycle memory cycle with exactly one direction
	a_single_strobe: assert property (@(posedge clk) disable iff (!n_reset)
		bus_memory |-> (bus_read != bus_write) ##1 !bus_memory);

	// Some device behind the slot always answers a read
	a_read_answered: assert property (@(posedge clk) disable iff (!n_reset)
		bus_read |=> bus_read_ready);

endmodule

`default_nettype wire

//--- verilog/msx_bus_pkg.sv
`default_nettype none

package msx_bus_pkg;

	// ----------------------------------------------------------
	// MSX-50BUS widths
	// ----------------------------------------------------------
	// Full 64 KB memory address
	typedef logic [15:0] bus_addr_t;
	// One data byte on the bus
	typedef logic [7:0] bus_data_t;
	// Subslot number, one of four devices behind the expanded slot
	typedef logic [1:0] subslot_t;
	// Expanded-slot register, two bits per 16 KB page, page 0 in bits 1:0
	typedef logic [7:0] slot_reg_t;

	// Expanded-slot register sits at the top of the address space
	localparam bus_addr_t EXTSLOT_ADDR = 16'hFFFF;

	// ----------------------------------------------------------
	// Command FIFO
	// ----------------------------------------------------------
	localparam int CMD_FIFO_DEPTH = 4;
	localparam int CMD_FIFO_PTR_BITS = $clog2(CMD_FIFO_DEPTH);

	// Pointer and fill count, count needs one bit more than the pointer
	typedef logic [CMD_FIFO_PTR_BITS-1:0] fifo_ptr_t;
	typedef logic [CMD_FIFO_PTR_BITS:0] fifo_count_t;

	localparam fifo_count_t CMD_FIFO_FULL = fifo_count_t'(CMD_FIFO_DEPTH);
	localparam fifo_ptr_t CMD_FIFO_LAST = fifo_ptr_t'(CMD_FIFO_DEPTH - 1);

	// ----------------------------------------------------------
	// Bus master FSM
	// ----------------------------------------------------------
	typedef enum logic [1:0] {
		IDLE,
		STROBE,
		WAIT_DATA,
		RESPOND
	} master_state_t;

endpackage

`default_nettype wire

//--- verilog/msx_cmd_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module msx_cmd_fifo import msx_bus_pkg::*; (
	input wire logic clk,
	input wire logic n_reset,
	// Host command port
	input wire logic cmd_valid,
	output logic cmd_ready,
	input wire logic cmd_write,
	input wire bus_addr_t cmd_address,
	input wire bus_data_t cmd_wdata,
	// Queue side towards the bus master
	output logic q_valid,
	input wire logic q_ready,
	output logic q_write,
	output bus_addr_t q_address,
	output bus_data_t q_wdata
);
	// Entry storage, one array per field
	logic ff_write_mem [CMD_FIFO_DEPTH];
	bus_addr_t ff_addr_mem [CMD_FIFO_DEPTH];
	bus_data_t ff_data_mem [CMD_FIFO_DEPTH];

	fifo_ptr_t ff_wr_ptr;
	fifo_ptr_t ff_rd_ptr;
	fifo_count_t ff_count;

	logic w_push;
	logic w_pop;

	// ----------------------------------------------------------
	// Handshakes
	// ----------------------------------------------------------
	assign cmd_ready = (ff_count != CMD_FIFO_FULL);
	assign q_valid = (ff_count != '0);
	assign w_push = cmd_valid && cmd_ready;
	assign w_pop = q_valid && q_ready;

	// Head entry is always on the queue outputs
	assign q_write = ff_write_mem[ff_rd_ptr];
	assign q_address = ff_addr_mem[ff_rd_ptr];
	assign q_wdata = ff_data_mem[ff_rd_ptr];

	// ----------------------------------------------------------
	// Pointers and count
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_wr_ptr <= '0;
			ff_rd_ptr <= '0;
			ff_count <= '0;
		end else begin
			// Pointers wrap after the last entry
			if (w_push) begin
				ff_wr_ptr <= (ff_wr_ptr == CMD_FIFO_LAST) ? '0 : ff_wr_ptr + 1'b1;
			end
			if (w_pop) begin
				ff_rd_ptr <= (ff_rd_ptr == CMD_FIFO_LAST) ? '0 : ff_rd_ptr + 1'b1;
			end
			// Push and pop together leave the count alone
			case ({w_push, w_pop})
				2'b10: ff_count <= ff_count + 1'b1;
				2'b01: ff_count <= ff_count - 1'b1;
				default: ff_count <= ff_count;
			endcase
		end
	end

	// Entry write
	always_ff @(posedge clk) begin
		if (w_push) begin
			ff_write_mem[ff_wr_ptr] <= cmd_write;
			ff_addr_mem[ff_wr_ptr] <= cmd_address;
			ff_data_mem[ff_wr_ptr] <= cmd_wdata;
		end
	end

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	// Fill level stays inside the buffer
	a_count_bound: assert property (@(posedge clk) disable iff (!n_reset)
		ff_count <= CMD_FIFO_FULL);

	// A full FIFO takes no entry, so the write pointer holds
	a_no_push_full: assert property (@(posedge clk) disable iff (!n_reset)
		(ff_count == CMD_FIFO_FULL) |=> (ff_wr_ptr == $past(ff_wr_ptr)));

endmodule

`default_nettype wire

//--- verilog/msx_extslot_top.sv
`timescale 1ns/10ps
`default_nettype none

module msx_extslot_top import msx_bus_pkg::*; (
	input wire logic clk,
	input wire logic n_reset,
	// Host command port
	input wire logic cmd_valid,
	output logic cmd_ready,
	input wire logic cmd_write,
	input wire bus_addr_t cmd_address,
	input wire bus_data_t cmd_wdata,
	// Host response port
	output logic rsp_valid,
	input wire logic rsp_ready,
	output bus_data_t rsp_rdata
);
	// FIFO to master
	logic q_valid;
	logic q_ready;
	logic q_write;
	bus_addr_t q_address;
	bus_data_t q_wdata;

	// Bus strobes from the master
	bus_addr_t bus_address;
	bus_data_t bus_write_data;
	logic bus_read;
	logic bus_write;
	logic bus_memory;

	// Subslot selects
	logic extslot_memory0;
	logic extslot_memory1;
	logic extslot_memory2;
	logic extslot_memory3;

	// Per-device read returns and their OR
	logic [4:0] w_ready;
	bus_data_t w_data [5];
	logic bus_read_ready;
	bus_data_t bus_read_data;

	// ----------------------------------------------------------
	// Command path
	// ----------------------------------------------------------
	msx_cmd_fifo u_fifo (
		.clk(clk),
		.n_reset(n_reset),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_write(cmd_write),
		.cmd_address(cmd_address),
		.cmd_wdata(cmd_wdata),
		.q_valid(q_valid),
		.q_ready(q_ready),
		.q_write(q_write),
		.q_address(q_address),
		.q_wdata(q_wdata)
	);

	msx_bus_master u_master (
		.clk(clk),
		.n_reset(n_reset),
		.q_valid(q_valid),
		.q_ready(q_ready),
		.q_write(q_write),
		.q_address(q_address),
		.q_wdata(q_wdata),
		.bus_address(bus_address),
		.bus_write_data(bus_write_data),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_memory(bus_memory),
		.bus_read_ready(bus_read_ready),
		.bus_read_data(bus_read_data),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp_rdata(rsp_rdata)
	);

	// ----------------------------------------------------------
	// Slot hardware
	// ----------------------------------------------------------
	ip_extslot u_extslot (
		.clk(clk),
		.n_reset(n_reset),
		.bus_address(bus_address),
		.bus_write_data(bus_write_data),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_memory(bus_memory),
		.bus_read_ready(w_ready[4]),
		.bus_read_data(w_data[4]),
		.extslot_memory0(extslot_memory0),
		.extslot_memory1(extslot_memory1),
		.extslot_memory2(extslot_memory2),
		.extslot_memory3(extslot_memory3)
	);

	// Subslot 0
	sub_slot_ram ram0 (
		.clk(clk),
		.n_reset(n_reset),
		.sel(extslot_memory0),
		.bus_address(bus_address),
		.bus_write_data(bus_write_data),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_read_ready(w_ready[0]),
		.bus_read_data(w_data[0])
	);

	// Subslot 1
	sub_slot_ram ram1 (
		.clk(clk),
		.n_reset(n_reset),
		.sel(extslot_memory1),
		.bus_address(bus_address),
		.bus_write_data(bus_write_data),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_read_ready(w_ready[1]),
		.bus_read_data(w_data[1])
	);

	// Subslot 2
	sub_slot_ram ram2 (
		.clk(clk),
		.n_reset(n_reset),
		.sel(extslot_memory2),
		.bus_address(bus_address),
		.bus_write_data(bus_write_data),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_read_ready(w_ready[2]),
		.bus_read_data(w_data[2])
	);

	// Subslot 3
	sub_slot_ram ram3 (
		.clk(clk),
		.n_reset(n_reset),
		.sel(extslot_memory3),
		.bus_address(bus_address),
		.bus_write_data(bus_write_data),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_read_ready(w_ready[3]),
		.bus_read_data(w_data[3])
	);

	// ----------------------------------------------------------
	// Read return OR
	// ----------------------------------------------------------
	// Idle devices drive zero, so a plain OR merges them
	assign bus_read_ready = |w_ready;
	assign bus_read_data = w_data[0] | w_data[1] | w_data[2] | w_data[3] | w_data[4];

endmodule

`default_nettype wire

//--- verilog/sub_slot_ram.sv
`timescale 1ns/10ps
`default_nettype none

module sub_slot_ram import msx_bus_pkg::*; #(
	// Decoded address bits, higher bits alias
	parameter int RAM_ADDR_BITS = 8
) (
	input wire logic clk,
	input wire logic n_reset,
	// Subslot select, already qualified with bus_memory
	input wire logic sel,
	// MSX-50BUS
	input wire bus_addr_t bus_address,
	input wire bus_data_t bus_write_data,
	input wire logic bus_read,
	input wire logic bus_write,
	output logic bus_read_ready,
	output bus_data_t bus_read_data
);
	localparam int RAM_WORDS = 2 ** RAM_ADDR_BITS;

	bus_data_t ff_mem [RAM_WORDS];
	logic [RAM_ADDR_BITS-1:0] w_index;
	logic ff_read_ready;
	bus_data_t ff_read_data;

	// Low address bits only
	assign w_index = bus_address[RAM_ADDR_BITS-1:0];

	// ----------------------------------------------------------
	// Storage
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (sel && bus_write) begin
			ff_mem[w_index] <= bus_write_data;
		end
		// Read byte sampled with the strobe
		if (sel && bus_read) begin
			ff_read_data <= ff_mem[w_index];
		end
	end

	// ----------------------------------------------------------
	// Read return
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_read_ready <= 1'b0;
		end else begin
			// Single-cycle pulse after each selected read
			ff_read_ready <= sel && bus_read;
		end
	end

	assign bus_read_ready = ff_read_ready;
	// Quiet bus when not answering, the top ORs all returns
	assign bus_read_data = ff_read_ready ? ff_read_data : '0;

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	// Decoder only selects during a strobe with one direction
	a_sel_strobe: assert property (@(posedge clk) disable iff (!n_reset)
		sel |-> (bus_read != bus_write));

endmodule

`default_nettype wire
